/* common/cp15_params.svh */
`ifndef CP15_PARAMS_SVH
`define CP15_PARAMS_SVH

// **************************************
// Register file
// **************************************

// Identification word returned by register 0
`define CP15_ID_VALUE 32'h60018247

`define CP15_NUM_REGS 16

// **************************************
// Cache maintenance
// **************************************

// Lines visited by one clean walk
`define CP15_CACHE_LINES 8
`define CP15_LINE_BITS 3

// Register numbers that trigger maintenance on write
`define CP15_CACHE_REG 7
`define CP15_TLB_REG 8

`endif

/* common/cp15Pkg.sv */
// Types for the register access path shared by the CPU and the MMU
package cp15Pkg;

  // **************************************
  // Register access
  // **************************************

  // Register number taken from the CRn field of the MCR/MRC encoding
  typedef logic [3:0] regAddr;

  // Register contents and transfer data
  typedef logic [31:0] regWord;

endpackage

/* common/maintPkg.sv */
`include "cp15_params.svh"

// Types for cache and TLB maintenance
package maintPkg;

  // **************************************
  // Instruction fields
  // **************************************

  typedef logic [2:0] opcode2Field;
  typedef logic [3:0] crmField;

  // **************************************
  // Clean walk
  // **************************************

  // Index of the cache line being cleaned
  typedef logic [`CP15_LINE_BITS-1:0] lineIndex;

  // Sequencer states
  // CLEAN walks the lines, PULSE drives the flush outputs for one cycle
  typedef enum logic [1:0] {
    IDLE,
    CLEAN,
    PULSE
  } maintState;

endpackage

/* maint/lineCounter.sv */
`include "cp15_params.svh"

module lineCounter (
  input  logic               clk,
  input  logic               reset,
  input  logic               countEnable,
  input  logic               countClear,
  output maintPkg::lineIndex cleanLine,
  output logic               lastLine
);

  import maintPkg::*;

  lineIndex count;

  // Clear wins over enable
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (countClear) begin
      count <= '0;
    end else if (countEnable) begin
      count <= count + 1'b1;
    end
  end

  assign cleanLine = count;
  assign lastLine  = (count == lineIndex'(`CP15_CACHE_LINES - 1));

endmodule

/* maint/maintDecoder.sv */
`include "cp15_params.svh"

module maintDecoder (
  input  logic                  accValid,
  input  logic                  accWrite,
  input  cp15Pkg::regAddr       accAddr,
  input  maintPkg::opcode2Field accOpcode2,
  input  maintPkg::crmField     accCrm,
  output logic                  opStart,
  output logic                  opFlushI,
  output logic                  opFlushD,
  output logic                  opCleanI,
  output logic                  opCleanD,
  output logic                  opTlbI,
  output logic                  opTlbD
);

  logic opWrite;
  logic cacheOp;
  logic tlbOp;

  // Only opcode2 0 and 1 are maintenance encodings
  assign opWrite = accValid & accWrite & (accOpcode2[2:1] == 2'b00);
  assign cacheOp = opWrite & (accAddr == 4'(`CP15_CACHE_REG));
  assign tlbOp   = opWrite & (accAddr == 4'(`CP15_TLB_REG));

  // **************************************
  // Register 7 cache operations
  // **************************************

  always_comb begin
    {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0000;
    if (cacheOp) begin
      case (accCrm)
        4'b0111: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b1100;
        4'b0101: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b1000;
        4'b0110: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0100;
        4'b1011: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0011;
        4'b1010: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0001;
        4'b1111: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b1111;
        // Clean and flush of the D side only
        4'b1110: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0101;
        default: {opFlushI, opFlushD, opCleanI, opCleanD} = 4'b0000;
      endcase
    end
  end

  // **************************************
  // Register 8 TLB operations
  // **************************************

  always_comb begin
    {opTlbI, opTlbD} = 2'b00;
    if (tlbOp) begin
      case (accCrm)
        4'b0111: {opTlbI, opTlbD} = 2'b11;
        4'b0101: {opTlbI, opTlbD} = 2'b10;
        4'b0110: {opTlbI, opTlbD} = 2'b01;
        default: {opTlbI, opTlbD} = 2'b00;
      endcase
    end
  end

  assign opStart = opFlushI | opFlushD | opCleanI | opCleanD | opTlbI | opTlbD;

endmodule

/* maint/maintSequencer.sv */
module maintSequencer (
  input  logic clk,
  input  logic reset,
  input  logic opStart,
  input  logic opFlushI,
  input  logic opFlushD,
  input  logic opCleanI,
  input  logic opCleanD,
  input  logic opTlbI,
  input  logic opTlbD,
  input  logic cleanReady,
  input  logic lastLine,
  output logic busy,
  output logic cleanValid,
  output logic cleanI,
  output logic cleanD,
  output logic flushI,
  output logic flushD,
  output logic tlbFlushI,
  output logic tlbFlushD,
  output logic countEnable,
  output logic countClear
);

  import maintPkg::*;

  maintState state;
  logic      startNow;
  logic      anyFlush;
  logic      lastDone;

  // Operation latched at acceptance
  logic flushIReg;
  logic flushDReg;
  logic cleanIReg;
  logic cleanDReg;
  logic tlbIReg;
  logic tlbDReg;

  assign startNow = (state == IDLE) & opStart;
  assign anyFlush = flushIReg | flushDReg | tlbIReg | tlbDReg;
  assign lastDone = countEnable & lastLine;

  // **************************************
  // State and operation latch
  // **************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      flushIReg <= 1'b0;
      flushDReg <= 1'b0;
      cleanIReg <= 1'b0;
      cleanDReg <= 1'b0;
      tlbIReg   <= 1'b0;
      tlbDReg   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (opStart) begin
            flushIReg <= opFlushI;
            flushDReg <= opFlushD;
            cleanIReg <= opCleanI;
            cleanDReg <= opCleanD;
            tlbIReg   <= opTlbI;
            tlbDReg   <= opTlbD;
            state     <= (opCleanI | opCleanD) ? CLEAN : PULSE;
          end
        end
        // Flushes wait until every line has been cleaned
        CLEAN: begin
          if (lastDone) begin
            state <= anyFlush ? PULSE : IDLE;
          end
        end
        PULSE:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // **************************************
  // Outputs
  // **************************************

  assign busy       = (state != IDLE);
  assign cleanValid = (state == CLEAN);
  assign cleanI     = cleanValid & cleanIReg;
  assign cleanD     = cleanValid & cleanDReg;

  assign flushI    = (state == PULSE) & flushIReg;
  assign flushD    = (state == PULSE) & flushDReg;
  assign tlbFlushI = (state == PULSE) & tlbIReg;
  assign tlbFlushD = (state == PULSE) & tlbDReg;

  // Line counter restarts at every new operation
  assign countEnable = cleanValid & cleanReady;
  assign countClear  = startNow;

endmodule

/* cp15/cp15RegFile.sv */
`include "cp15_params.svh"

module cp15RegFile (
  input  logic            clk,
  input  logic            reset,
  input  logic            accValid,
  input  logic            accWrite,
  input  cp15Pkg::regAddr accAddr,
  input  cp15Pkg::regWord accData,
  input  logic            accFromMmu,
  output logic            cpuReadValid,
  output logic            mmuReadValid,
  output cp15Pkg::regWord readData,
  output cp15Pkg::regWord control,
  output cp15Pkg::regWord tbase
);

  import cp15Pkg::*;

  regWord rf [`CP15_NUM_REGS];
  logic   readPending;
  logic   writeEn;

  // Register 0 holds the ID and never takes a write
  assign writeEn = accValid & accWrite & (accAddr != '0);

  // **************************************
  // Register write
  // **************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      rf[0] <= `CP15_ID_VALUE;
      for (int i = 1; i < `CP15_NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (writeEn) begin
      rf[accAddr] <= accData;
    end
  end

  // **************************************
  // Registered read
  // **************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      readPending <= 1'b0;
    end else begin
      readPending <= accValid & ~accWrite;
    end
  end

  // Captured before any same-edge write lands
  always_ff @(posedge clk) begin
    if (accValid && !accWrite) begin
      readData <= rf[accAddr];
    end
  end

  // accFromMmu is the arbiter's grant record for the previous cycle
  assign cpuReadValid = readPending & ~accFromMmu;
  assign mmuReadValid = readPending & accFromMmu;

  // Always visible to the MMU and the pipeline
  assign control = rf[1];
  assign tbase   = rf[2];

endmodule

/* cp15/cp15AccessArbiter.sv */
module cp15AccessArbiter (
  input  logic                  clk,
  input  logic                  reset,
  // CPU side, MCR/MRC
  input  logic                  cpuValid,
  input  logic                  cpuWrite,
  input  cp15Pkg::regAddr       cpuAddr,
  input  cp15Pkg::regWord       cpuWriteData,
  input  maintPkg::opcode2Field cpuOpcode2,
  input  maintPkg::crmField     cpuCrm,
  // MMU side
  input  logic                  mmuValid,
  input  logic                  mmuWrite,
  input  cp15Pkg::regAddr       mmuAddr,
  input  cp15Pkg::regWord       mmuWriteData,
  input  logic                  busy,
  output logic                  cpuReady,
  output logic                  mmuReady,
  output logic                  accValid,
  output logic                  accWrite,
  output cp15Pkg::regAddr       accAddr,
  output cp15Pkg::regWord       accData,
  output maintPkg::opcode2Field accOpcode2,
  output maintPkg::crmField     accCrm,
  output logic                  accFromMmu
);

  logic mmuGrant;
  logic cpuGrant;
  logic grantMmu;

  // MMU wins any conflict, the CPU stalls behind it
  assign mmuReady = ~busy;
  assign cpuReady = ~busy & ~mmuValid;

  assign mmuGrant = mmuValid & mmuReady;
  assign cpuGrant = cpuValid & cpuReady;
  assign accValid = mmuGrant | cpuGrant;

  // **************************************
  // Granted access
  // **************************************

  assign accWrite = mmuValid ? mmuWrite     : cpuWrite;
  assign accAddr  = mmuValid ? mmuAddr      : cpuAddr;
  assign accData  = mmuValid ? mmuWriteData : cpuWriteData;

  // MMU accesses carry no maintenance fields
  assign accOpcode2 = mmuValid ? '0 : cpuOpcode2;
  assign accCrm     = mmuValid ? '0 : cpuCrm;

  // **************************************
  // Grant record for read routing
  // **************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      grantMmu <= 1'b0;
    end else if (accValid) begin
      grantMmu <= mmuGrant;
    end
  end

  assign accFromMmu = grantMmu;

endmodule

/* logic/cp15Subsystem.sv */
module cp15Subsystem (
  input  logic                  clk,
  input  logic                  reset,
  // CPU requester
  input  logic                  cpuValid,
  input  logic                  cpuWrite,
  input  cp15Pkg::regAddr       cpuAddr,
  input  cp15Pkg::regWord       cpuWriteData,
  input  maintPkg::opcode2Field cpuOpcode2,
  input  maintPkg::crmField     cpuCrm,
  output logic                  cpuReady,
  output cp15Pkg::regWord       cpuReadData,
  output logic                  cpuReadValid,
  // MMU requester
  input  logic                  mmuValid,
  input  logic                  mmuWrite,
  input  cp15Pkg::regAddr       mmuAddr,
  input  cp15Pkg::regWord       mmuWriteData,
  output logic                  mmuReady,
  output cp15Pkg::regWord       mmuReadData,
  output logic                  mmuReadValid,
  // Cache and TLB maintenance
  input  logic                  cleanReady,
  output logic                  cleanValid,
  output maintPkg::lineIndex    cleanLine,
  output logic                  cleanI,
  output logic                  cleanD,
  output logic                  flushI,
  output logic                  flushD,
  output logic                  tlbFlushI,
  output logic                  tlbFlushD,
  output cp15Pkg::regWord       control,
  output cp15Pkg::regWord       tbase
);

  import cp15Pkg::*;
  import maintPkg::*;

  // Granted access
  logic        accValid;
  logic        accWrite;
  regAddr      accAddr;
  regWord      accData;
  opcode2Field accOpcode2;
  crmField     accCrm;
  logic        accFromMmu;

  regWord readData;

  // Decoded operation
  logic opStart;
  logic opFlushI;
  logic opFlushD;
  logic opCleanI;
  logic opCleanD;
  logic opTlbI;
  logic opTlbD;

  logic busy;
  logic countEnable;
  logic countClear;
  logic lastLine;

  // **************************************
  // Register access
  // **************************************

  cp15AccessArbiter arbiter (
    .clk, .reset,
    .cpuValid, .cpuWrite, .cpuAddr, .cpuWriteData, .cpuOpcode2, .cpuCrm,
    .mmuValid, .mmuWrite, .mmuAddr, .mmuWriteData,
    .busy,
    .cpuReady, .mmuReady,
    .accValid, .accWrite, .accAddr, .accData, .accOpcode2, .accCrm, .accFromMmu
  );

  cp15RegFile regFile (
    .clk, .reset,
    .accValid, .accWrite, .accAddr, .accData, .accFromMmu,
    .cpuReadValid, .mmuReadValid,
    .readData, .control, .tbase
  );

  // Both ports see the same data, the valids tell them apart
  assign cpuReadData = readData;
  assign mmuReadData = readData;

  // **************************************
  // Maintenance
  // **************************************

  maintDecoder decoder (
    .accValid, .accWrite, .accAddr, .accOpcode2, .accCrm,
    .opStart, .opFlushI, .opFlushD, .opCleanI, .opCleanD, .opTlbI, .opTlbD
  );

  maintSequencer sequencer (
    .clk, .reset,
    .opStart, .opFlushI, .opFlushD, .opCleanI, .opCleanD, .opTlbI, .opTlbD,
    .cleanReady, .lastLine,
    .busy, .cleanValid, .cleanI, .cleanD,
    .flushI, .flushD, .tlbFlushI, .tlbFlushD,
    .countEnable, .countClear
  );

  lineCounter counter (
    .clk, .reset,
    .countEnable, .countClear,
    .cleanLine, .lastLine
  );

endmodule

/* tb/cp15SubsystemTb.sv */
`include "cp15_params.svh"

module cp15SubsystemTb;

  timeunit 1ns;
  timeprecision 1ps;

  import cp15Pkg::*;
  import maintPkg::*;

  localparam int timeoutCycles = 200;
  localparam int lastLineIdx   = `CP15_CACHE_LINES - 1;

  logic        clk;
  logic        reset;
  logic        cpuValid, cpuWrite, cpuReady, cpuReadValid;
  regAddr      cpuAddr;
  regWord      cpuWriteData, cpuReadData;
  opcode2Field cpuOpcode2;
  crmField     cpuCrm;
  logic        mmuValid, mmuWrite, mmuReady, mmuReadValid;
  regAddr      mmuAddr;
  regWord      mmuWriteData, mmuReadData;
  logic        cleanReady, cleanValid, cleanI, cleanD;
  lineIndex    cleanLine;
  logic        flushI, flushD, tlbFlushI, tlbFlushD;
  regWord      control, tbase;

  int          seed = 32;
  logic [31:0] randomWord;
  logic [31:0] readyWord;

  // Reference model state
  regWord      refRegs [`CP15_NUM_REGS];
  logic        readDue;
  logic        readFromMmu;
  regWord      readExpected;
  logic [3:0]  pulseDue;
  logic [3:0]  pendingFlush;
  logic        cleanActive;
  logic        cleanExpI;
  logic        cleanExpD;
  logic        busyNow;
  int          cleanExpLine;
  int          linesDelivered;
  int          cleanOps;

  cp15Subsystem cp15Subsystem_inst (.*);

  always #50 clk = ~clk;

  // Cache model that back-pressures the clean stream at random
  always @(posedge clk) begin
    #1;
    readyWord = $random(seed);
    cleanReady = readyWord[0];
  end

  // **************************************
  // Failure reporting
  // **************************************

  task automatic stopRun();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic reportMismatch(input string what);
    $display("Mismatch at time %0d ns: %s", $time, what);
    stopRun();
  endtask

  task automatic reportFailure(input string what);
    $display("Error at time %0d ns: %s", $time, what);
    stopRun();
  endtask

  // Bits are flushI, flushD, cleanI, cleanD, tlbI, tlbD
  function automatic logic [5:0] expectedFlags(regAddr addr, opcode2Field op2, crmField crm);
    logic [5:0] flags;
    flags = 6'b000000;
    if (op2 <= 3'd1 && addr == 4'(`CP15_CACHE_REG)) begin
      case (crm)
        4'b0111: flags = 6'b110000;
        4'b0101: flags = 6'b100000;
        4'b0110: flags = 6'b010000;
        4'b1011: flags = 6'b001100;
        4'b1010: flags = 6'b000100;
        4'b1111: flags = 6'b111100;
        4'b1110: flags = 6'b010100;
        default: flags = 6'b000000;
      endcase
    end else if (op2 <= 3'd1 && addr == 4'(`CP15_TLB_REG)) begin
      case (crm)
        4'b0111: flags = 6'b000011;
        4'b0101: flags = 6'b000010;
        4'b0110: flags = 6'b000001;
        default: flags = 6'b000000;
      endcase
    end
    return flags;
  endfunction

  // Model effect of one accepted access
  task automatic applyAccess(input logic fromMmu, input logic write, input regAddr addr,
                             input regWord data, input opcode2Field op2, input crmField crm);
    logic [5:0] flags;
    flags = 6'b000000;
    if (write && !fromMmu) begin
      flags = expectedFlags(addr, op2, crm);
    end
    if (!write) begin
      readDue      = 1'b1;
      readFromMmu  = fromMmu;
      readExpected = refRegs[addr];
    end else if (addr != 4'd0) begin
      refRegs[addr] = data;
    end
    if (flags[3:2] != 2'b00) begin
      cleanActive  = 1'b1;
      cleanExpLine = 0;
      cleanExpI    = flags[3];
      cleanExpD    = flags[2];
      pendingFlush = {flags[5:4], flags[1:0]};
      cleanOps++;
    end else begin
      pulseDue = {flags[5:4], flags[1:0]};
    end
  endtask

  // **************************************
  // Cycle checks at the falling edge
  // **************************************

  always @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CP15_NUM_REGS; i++) begin
        refRegs[regAddr'(i)] = '0;
      end
      refRegs[0]     = `CP15_ID_VALUE;
      readDue        = 1'b0;
      pulseDue       = 4'b0000;
      cleanActive    = 1'b0;
      linesDelivered = 0;
      cleanOps       = 0;
    end else begin
      assert (cpuReadValid == (readDue && !readFromMmu))
        else reportMismatch("cpuReadValid differs from the model");
      assert (mmuReadValid == (readDue && readFromMmu))
        else reportMismatch("mmuReadValid differs from the model");
      if (readDue && readFromMmu) begin
        assert (mmuReadData == readExpected)
          else reportMismatch($sformatf("MMU read %h, expected %h", mmuReadData, readExpected));
      end
      if (readDue && !readFromMmu) begin
        assert (cpuReadData == readExpected)
          else reportMismatch($sformatf("CPU read %h, expected %h", cpuReadData, readExpected));
      end
      assert ({flushI, flushD, tlbFlushI, tlbFlushD} == pulseDue)
        else reportMismatch($sformatf("flush pulses %b, expected %b",
                                      {flushI, flushD, tlbFlushI, tlbFlushD}, pulseDue));
      busyNow = cleanActive || (pulseDue != 4'b0000);
      assert (mmuReady == !busyNow) else reportMismatch("mmuReady differs from the model");
      assert (cpuReady == (!busyNow && !mmuValid))
        else reportMismatch("cpuReady differs from the model");
      assert (control == refRegs[1]) else reportMismatch("control differs from register 1");
      assert (tbase == refRegs[2]) else reportMismatch("tbase differs from register 2");

      // Lines the DUT hands over at the coming edge
      if (cleanValid && cleanReady) begin
        linesDelivered++;
      end

      readDue  = 1'b0;
      pulseDue = 4'b0000;
      if (cleanActive) begin
        assert (cleanValid && cleanLine == lineIndex'(cleanExpLine))
          else reportMismatch($sformatf("clean line %0d, expected %0d", cleanLine, cleanExpLine));
        assert (cleanI == cleanExpI && cleanD == cleanExpD)
          else reportMismatch("cleanI or cleanD differs from the table");
        if (cleanReady) begin
          if (cleanExpLine == lastLineIdx) begin
            cleanActive = 1'b0;
            pulseDue    = pendingFlush;
          end else begin
            cleanExpLine++;
          end
        end
      end else begin
        assert (!cleanValid && !cleanI && !cleanD)
          else reportMismatch("clean stream active outside a clean walk");
      end

      if (mmuValid && mmuReady) begin
        applyAccess(1'b1, mmuWrite, mmuAddr, mmuWriteData, 3'd0, 4'd0);
      end else if (cpuValid && cpuReady) begin
        applyAccess(1'b0, cpuWrite, cpuAddr, cpuWriteData, cpuOpcode2, cpuCrm);
      end
    end
  end

  // **************************************
  // Protocol properties
  // **************************************

  mmuPriority: assert property (@(posedge clk) disable iff (reset) mmuValid |-> !cpuReady)
    else reportFailure("CPU was ready while the MMU was requesting");

  stallDuringClean: assert property (@(posedge clk) disable iff (reset)
    cleanValid |-> !cpuReady && !mmuReady)
    else reportFailure("A requester was ready during the clean walk");

  cleanHold: assert property (@(posedge clk) disable iff (reset)
    cleanValid && !cleanReady |=> cleanValid && $stable(cleanLine))
    else reportFailure("Clean request dropped or changed under back-pressure");

  singlePulse: assert property (@(posedge clk) disable iff (reset)
    (flushI || flushD || tlbFlushI || tlbFlushD) |=> !(flushI || flushD || tlbFlushI || tlbFlushD))
    else reportFailure("A flush pulse lasted more than one cycle");

  // **************************************
  // Requester tasks
  // **************************************

  task automatic acceptCpu();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cpuReady) begin
      waited++;
      if (waited > timeoutCycles) begin
        reportFailure("CPU request was not accepted before the timeout");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cpuValid = 1'b0;
  endtask

  task automatic cpuAccess(input logic write, input regAddr addr, input regWord data,
                           input opcode2Field op2, input crmField crm);
    cpuValid     = 1'b1;
    cpuWrite     = write;
    cpuAddr      = addr;
    cpuWriteData = data;
    cpuOpcode2   = op2;
    cpuCrm       = crm;
    acceptCpu();
  endtask

  task automatic mmuAccess(input logic write, input regAddr addr, input regWord data);
    int waited;
    waited       = 0;
    mmuValid     = 1'b1;
    mmuWrite     = write;
    mmuAddr      = addr;
    mmuWriteData = data;
    @(negedge clk);
    while (!mmuReady) begin
      waited++;
      if (waited > timeoutCycles) begin
        reportFailure("MMU request was not accepted before the timeout");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    mmuValid = 1'b0;
  endtask

  // Waits until a maintenance operation has finished
  task automatic waitIdle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!mmuReady) begin
      waited++;
      if (waited > timeoutCycles) begin
        reportFailure("Maintenance operation did not finish before the timeout");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // **************************************
  // Stimulus
  // **************************************

  initial begin
    reset        = 1'b1;
    clk          = 1'b0;
    cpuValid     = 1'b0;
    cpuWrite     = 1'b0;
    cpuAddr      = '0;
    cpuWriteData = '0;
    cpuOpcode2   = '0;
    cpuCrm       = '0;
    mmuValid     = 1'b0;
    mmuWrite     = 1'b0;
    mmuAddr      = '0;
    mmuWriteData = '0;
    cleanReady   = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // State right after reset
    @(negedge clk);
    assert (control == '0 && tbase == '0) else reportMismatch("control or tbase not zero");
    assert (!cleanValid && !flushI && !flushD && !tlbFlushI && !tlbFlushD)
      else reportMismatch("maintenance outputs active after reset");
    assert (cpuReady && mmuReady) else reportMismatch("ready low after reset");
    @(posedge clk);
    #1;
    cpuAccess(1'b0, 4'd0, '0, '0, '0);
    cpuAccess(1'b0, 4'd1, '0, '0, '0);
    mmuAccess(1'b0, 4'd2, '0);

    // Random register traffic from both sides, register 0 included
    cpuAccess(1'b1, 4'd0, 32'hdeadbeef, '0, '0);
    mmuAccess(1'b1, 4'd0, 32'h12345678);
    for (int i = 0; i < 60; i++) begin
      randomWord = $random(seed);
      if (randomWord[4]) begin
        mmuAccess(randomWord[5], randomWord[3:0], $random(seed));
      end else begin
        cpuAccess(randomWord[5], randomWord[3:0], $random(seed), '0, '0);
      end
    end
    for (int r = 0; r < `CP15_NUM_REGS; r++) begin
      cpuAccess(1'b0, regAddr'(r), '0, '0, '0);
      mmuAccess(1'b0, regAddr'(r), '0);
    end

    // Both requesters in the same cycle
    mmuValid     = 1'b1;
    mmuWrite     = 1'b1;
    mmuAddr      = 4'd4;
    mmuWriteData = 32'ha5a5f00d;
    cpuValid     = 1'b1;
    cpuWrite     = 1'b0;
    cpuAddr      = 4'd4;
    @(negedge clk);
    assert (mmuReady && !cpuReady) else reportMismatch("MMU did not win the conflict");
    @(posedge clk);
    #1;
    mmuValid = 1'b0;
    acceptCpu();

    // Every maintenance code, flush and clean
    for (int r = `CP15_CACHE_REG; r <= `CP15_TLB_REG; r++) begin
      for (int op2 = 0; op2 < 3; op2++) begin
        for (int c = 0; c < 16; c++) begin
          randomWord = $random(seed);
          cpuAccess(1'b1, regAddr'(r), randomWord, opcode2Field'(op2), crmField'(c));
          waitIdle();
        end
      end
    end
    mmuAccess(1'b1, 4'(`CP15_CACHE_REG), 32'h0000000f);
    mmuAccess(1'b1, 4'(`CP15_TLB_REG), 32'h00000007);
    waitIdle();

    if (cleanOps > 0 && linesDelivered == cleanOps * `CP15_CACHE_LINES) begin
      $display("All checks passed");
      $finish;
    end else begin
      reportFailure("Clean walks did not deliver every cache line");
    end
  end

endmodule

/* src.f */
+incdir+common
common/cp15Pkg.sv
common/maintPkg.sv
maint/lineCounter.sv
maint/maintDecoder.sv
maint/maintSequencer.sv
cp15/cp15RegFile.sv
cp15/cp15AccessArbiter.sv
logic/cp15Subsystem.sv
tb/cp15SubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cp15SubsystemTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
